/* verilog/w5500_reg_pkg.sv */
package w5500_reg_pkg;

	// common register block.
	localparam logic [15:0] GAR0          = 16'h0001;
	localparam logic [15:0] SUBR0         = 16'h0005;
	localparam logic [15:0] SHAR0         = 16'h0009;
	localparam logic [15:0] SIPR0         = 16'h000F;
	localparam logic [15:0] RTR0          = 16'h0019;
	localparam logic [15:0] RCR           = 16'h001B;
	localparam logic [15:0] PHYCFGR       = 16'h002E;

	// socket n register block.
	localparam logic [15:0] SN_MR         = 16'h0000;
	localparam logic [15:0] SN_CR         = 16'h0001;
	localparam logic [15:0] SN_IR         = 16'h0002;
	localparam logic [15:0] SN_SR         = 16'h0003;
	localparam logic [15:0] SN_PORT0      = 16'h0004;
	localparam logic [15:0] SN_DIPR0      = 16'h000C;
	localparam logic [15:0] SN_DPORT0     = 16'h0010;
	localparam logic [15:0] SN_RXBUF_SIZE = 16'h001E;
	localparam logic [15:0] SN_TXBUF_SIZE = 16'h001F;
	localparam logic [15:0] SN_TX_FSR0    = 16'h0020;
	localparam logic [15:0] SN_TX_WR0     = 16'h0024;
	localparam logic [15:0] SN_RX_RSR0    = 16'h0026;
	localparam logic [15:0] SN_RX_RD0     = 16'h0028;
	localparam logic [15:0] SN_KPALVTR    = 16'h002F;

	localparam logic [1:0] BSB_COMMON   = 2'b00; // socket field is zero here.
	localparam logic [1:0] BSB_SOCK_REG = 2'b01;
	localparam logic [1:0] BSB_SOCK_TX  = 2'b10;
	localparam logic [1:0] BSB_SOCK_RX  = 2'b11;

	localparam int          CTRL_RWB_BIT = 2;
	localparam logic [1:0]  CTRL_OM      = 2'b00; // variable length data mode.

	localparam logic [15:0] LEN_U8   = 16'd1;
	localparam logic [15:0] LEN_U16  = 16'd2;
	localparam logic [15:0] LEN_IPV4 = 16'd4;
	localparam logic [15:0] LEN_MAC  = 16'd6;

endpackage

/* verilog/w5500_cmd_pkg.sv */
package w5500_cmd_pkg;

	localparam int BUF_AW = 11;
	localparam int SIZE_W = 16;

	typedef enum logic [7:0] {
		GATEWAY        = 8'h01,
		NETMASK        = 8'h02,
		SMAC           = 8'h03,
		SIP            = 8'h04,
		PHY_STATE      = 8'h05,
		RETRY_TIME     = 8'h06,
		RETRY_COUNT    = 8'h07,
		SOCK_MODE      = 8'h10,
		SOCK_CMD       = 8'h11,
		SOCK_INT       = 8'h12,
		SOCK_STATE     = 8'h13,
		SOCK_SPORT     = 8'h14,
		SOCK_RBUF_SIZE = 8'h15,
		SOCK_TBUF_SIZE = 8'h16,
		SOCK_TX_FSIZE  = 8'h17,
		SOCK_TX_WPOINT = 8'h18,
		SOCK_RX_SIZE   = 8'h19,
		SOCK_RX_RPOINT = 8'h1A,
		SOCK_KEEPALIVE = 8'h1B,
		SOCK_DIP       = 8'h1C,
		SOCK_DPORT     = 8'h1D,
		SOCK_BUF       = 8'h20
	} w5500_cmd_e;

	typedef enum logic {
		RW_READ  = 1'b0,
		RW_WRITE = 1'b1
	} rw_e;

	typedef enum logic [3:0] {
		IDLE,
		CS_LOW,
		ADDR,
		ADDR_ACK,
		CTRL,
		CTRL_ACK,
		BYTE,
		BYTE_ACK,
		CS_HIGH
	} cmd_state_e;

endpackage

/* verilog/spi_byte_if.sv */
`timescale 1ns/1ps

interface spi_byte_if;
	logic       cs_ctrl; // low keeps chip select asserted.
	logic       wr_req;
	logic       wr_ack;
	logic [7:0] tx_byte;
	logic [7:0] rx_byte;

	modport master (
		output cs_ctrl,
		output wr_req,
		output tx_byte,
		input  wr_ack,
		input  rx_byte
	);

	modport slave (
		input  cs_ctrl,
		input  wr_req,
		input  tx_byte,
		output wr_ack,
		output rx_byte
	);
endinterface

/* verilog/send_buffer.sv */
`timescale 1ns/1ps

module send_buffer (
	input  logic                             clk,
	input  logic                             i_wr_en,
	input  logic [w5500_cmd_pkg::BUF_AW-1:0] i_wr_addr,
	input  logic [7:0]                       i_wr_data,
	input  logic [w5500_cmd_pkg::BUF_AW-1:0] i_rd_addr,
	output logic [7:0]                       o_rd_data
);
	import w5500_cmd_pkg::*;

	localparam int DEPTH = 1 << BUF_AW;

	logic [7:0] mem [0:DEPTH-1];

	// host side, staged before the command is issued.
	always_ff @(posedge clk) begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
	end

	always_ff @(posedge clk) begin
		o_rd_data <= mem[i_rd_addr]; // one cycle behind the address.
	end

endmodule

/* verilog/spi_w5500_cmd.sv */
`timescale 1ns/1ps

module spi_w5500_cmd (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [7:0]                       i_cmd,
	input  logic                             i_cmd_valid,
	input  logic [2:0]                       i_sock_num,
	input  logic                             i_rw,
	input  logic [15:0]                      i_addr,
	input  logic [w5500_cmd_pkg::SIZE_W-1:0] i_byte_size,
	output logic                             o_cmd_ack,
	output logic                             o_cmd_err,
	output logic [w5500_cmd_pkg::BUF_AW-1:0] o_buf_rd_addr,
	input  logic [7:0]                       i_buf_rd_data,
	output logic [7:0]                       o_data_out,
	output logic                             o_data_valid,
	spi_byte_if.master                       spi
);
	import w5500_cmd_pkg::*;
	import w5500_reg_pkg::*;

	cmd_state_e        state;
	cmd_state_e        next_state;

	w5500_cmd_e        r_cmd;
	logic [2:0]        r_sock;
	rw_e               r_rw;
	logic [15:0]       r_addr_in;
	logic [SIZE_W-1:0] r_size_in;

	logic [15:0]       dec_addr;
	logic [SIZE_W-1:0] dec_len;
	logic [1:0]        dec_bsb;
	logic [2:0]        dec_sock;
	rw_e               dec_rw;
	logic              dec_ok;

	logic [15:0]       r_addr;
	logic [7:0]        r_ctrl;
	logic [SIZE_W:0]   r_last; // index of the final frame byte.
	logic [SIZE_W:0]   byte_cnt;
	logic              r_err;
	logic              is_write;

	assign is_write = (r_ctrl[CTRL_RWB_BIT] == RW_WRITE);

	always_comb begin
		dec_addr = 16'h0000;
		dec_len = '0;
		dec_bsb = BSB_SOCK_REG;
		dec_rw = r_rw;
		dec_ok = 1'b1;
		case (r_cmd)
			GATEWAY:        {dec_bsb, dec_addr, dec_len} = {BSB_COMMON, GAR0, LEN_IPV4};
			NETMASK:        {dec_bsb, dec_addr, dec_len} = {BSB_COMMON, SUBR0, LEN_IPV4};
			SMAC:           {dec_bsb, dec_addr, dec_len} = {BSB_COMMON, SHAR0, LEN_MAC};
			SIP:            {dec_bsb, dec_addr, dec_len} = {BSB_COMMON, SIPR0, LEN_IPV4};
			PHY_STATE:      {dec_bsb, dec_addr, dec_len} = {BSB_COMMON, PHYCFGR, LEN_U8};
			RETRY_TIME:     {dec_bsb, dec_addr, dec_len} = {BSB_COMMON, RTR0, LEN_U16};
			RETRY_COUNT:    {dec_bsb, dec_addr, dec_len} = {BSB_COMMON, RCR, LEN_U8};
			SOCK_MODE:      {dec_addr, dec_len} = {SN_MR, LEN_U8};
			SOCK_CMD:       {dec_addr, dec_len} = {SN_CR, LEN_U8};
			SOCK_INT:       {dec_addr, dec_len} = {SN_IR, LEN_U8};
			SOCK_STATE:     {dec_addr, dec_len} = {SN_SR, LEN_U8};
			SOCK_SPORT:     {dec_addr, dec_len} = {SN_PORT0, LEN_U16};
			SOCK_RBUF_SIZE: {dec_addr, dec_len} = {SN_RXBUF_SIZE, LEN_U8};
			SOCK_TBUF_SIZE: {dec_addr, dec_len} = {SN_TXBUF_SIZE, LEN_U8};
			SOCK_TX_WPOINT: {dec_addr, dec_len} = {SN_TX_WR0, LEN_U16};
			SOCK_RX_RPOINT: {dec_addr, dec_len} = {SN_RX_RD0, LEN_U16};
			SOCK_KEEPALIVE: {dec_addr, dec_len} = {SN_KPALVTR, LEN_U8};
			SOCK_DIP:       {dec_addr, dec_len} = {SN_DIPR0, LEN_IPV4};
			SOCK_DPORT:     {dec_addr, dec_len} = {SN_DPORT0, LEN_U16};
			SOCK_TX_FSIZE: begin
				{dec_addr, dec_len} = {SN_TX_FSR0, LEN_U16};
				dec_rw = RW_READ; // read only register.
			end
			SOCK_RX_SIZE: begin
				{dec_addr, dec_len} = {SN_RX_RSR0, LEN_U16};
				dec_rw = RW_READ;
			end
			SOCK_BUF: begin
				{dec_addr, dec_len} = {r_addr_in, r_size_in};
				dec_bsb = (r_rw == RW_WRITE) ? BSB_SOCK_TX : BSB_SOCK_RX;
			end
			default: dec_ok = 1'b0;
		endcase
		dec_sock = (dec_bsb == BSB_COMMON) ? 3'd0 : r_sock;
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE:     if (i_cmd_valid) next_state = CS_LOW;
			CS_LOW:   next_state = dec_ok ? ADDR : CS_HIGH;
			ADDR:     next_state = ADDR_ACK;
			ADDR_ACK: if (spi.wr_ack) next_state = (byte_cnt == '0) ? ADDR : CTRL;
			CTRL:     next_state = CTRL_ACK;
			CTRL_ACK, BYTE_ACK: begin
				if (spi.wr_ack)
					next_state = (byte_cnt == r_last) ? CS_HIGH : BYTE;
			end
			BYTE:     next_state = BYTE_ACK;
			CS_HIGH:  next_state = IDLE;
			default:  next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			byte_cnt <= '0;
			r_err <= 1'b0;
			o_buf_rd_addr <= '0;
			spi.wr_req <= 1'b0;
			spi.cs_ctrl <= 1'b1;
			o_cmd_ack <= 1'b0;
			o_cmd_err <= 1'b0;
			o_data_valid <= 1'b0;
		end else begin
			state <= next_state;
			spi.wr_req <= (next_state inside {ADDR, CTRL, BYTE});
			spi.cs_ctrl <= (next_state inside {IDLE, CS_LOW, CS_HIGH});
			o_cmd_ack <= (state == CS_HIGH) && !r_err;
			o_cmd_err <= (state == CS_HIGH) && r_err;
			o_data_valid <= (state == BYTE_ACK) && spi.wr_ack && !is_write;
			if (state == IDLE)
				byte_cnt <= '0;
			else if (spi.wr_ack)
				byte_cnt <= byte_cnt + 1'b1;
			if (state == CS_LOW)
				r_err <= !dec_ok;
			if (state == IDLE)
				o_buf_rd_addr <= '0;
			else if (state == BYTE && is_write)
				o_buf_rd_addr <= o_buf_rd_addr + 1'b1; // byte already loaded.
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && i_cmd_valid) begin
			r_cmd <= w5500_cmd_e'(i_cmd);
			r_sock <= i_sock_num;
			r_rw <= rw_e'(i_rw);
			r_addr_in <= i_addr;
			r_size_in <= i_byte_size;
		end
		if (state == CS_LOW) begin
			r_addr <= dec_addr;
			r_ctrl <= {dec_sock, dec_bsb, dec_rw, CTRL_OM};
			r_last <= {1'b0, dec_len} + 2'd2;
		end
		if (next_state == ADDR)
			spi.tx_byte <= (state == CS_LOW) ? dec_addr[15:8] : r_addr[7:0];
		else if (next_state == CTRL)
			spi.tx_byte <= r_ctrl;
		else if (next_state == BYTE)
			spi.tx_byte <= is_write ? i_buf_rd_data : 8'h00;
		if (state == BYTE_ACK && spi.wr_ack)
			o_data_out <= spi.rx_byte;
	end

	// chip select held through every acknowledged byte.
	a_cs_frame: assert property (@(posedge clk) disable iff (!rst_n)
		spi.wr_ack |-> !spi.cs_ctrl);

	// an ack only lands while a byte is outstanding.
	a_ack_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
		spi.wr_ack |-> (state inside {ADDR_ACK, CTRL_ACK, BYTE_ACK}));

	// an address byte needs all sixteen sclk edges before its ack.
	a_addr_ack_len: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(state == ADDR_ACK) |-> (state == ADDR_ACK) [*16]);

endmodule

/* verilog/spi_master_eth.sv */
`timescale 1ns/1ps

module spi_master_eth (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [15:0] i_clk_div,
	spi_byte_if.slave   spi,
	output logic        o_spi_cs,
	output logic        o_spi_sclk,
	output logic        o_spi_mosi,
	input  logic        i_spi_miso
);

	logic        busy;
	logic [15:0] div_cnt;
	logic [4:0]  edge_cnt; // sixteen sclk edges per byte.
	logic [7:0]  tx_sh;
	logic [7:0]  rx_sh;
	logic        tick;

	assign tick = busy && (div_cnt >= i_clk_div);
	assign o_spi_mosi = tx_sh[7]; // msb first.
	assign spi.rx_byte = rx_sh;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			div_cnt <= '0;
			edge_cnt <= '0;
			tx_sh <= 8'h00;
			o_spi_sclk <= 1'b0;
			o_spi_cs <= 1'b1;
			spi.wr_ack <= 1'b0;
		end else begin
			o_spi_cs <= spi.cs_ctrl;
			spi.wr_ack <= 1'b0;
			if (!busy) begin
				div_cnt <= '0;
				edge_cnt <= '0;
				if (spi.wr_req) begin
					busy <= 1'b1;
					tx_sh <= spi.tx_byte; // bit 7 out ahead of the first rise.
				end
			end else if (tick) begin
				div_cnt <= '0;
				o_spi_sclk <= !o_spi_sclk;
				edge_cnt <= edge_cnt + 1'b1;
				if (o_spi_sclk)
					tx_sh <= {tx_sh[6:0], 1'b0}; // falling edge.
				if (edge_cnt == 5'd15) begin
					busy <= 1'b0;
					spi.wr_ack <= 1'b1;
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// miso sampled on the rising edge.
	always_ff @(posedge clk) begin
		if (tick && !o_spi_sclk)
			rx_sh <= {rx_sh[6:0], i_spi_miso};
	end

	a_req_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		spi.wr_req |-> !busy);

endmodule

/* verilog/w5500_spi_top.sv */
`timescale 1ns/1ps

module w5500_spi_top (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [15:0]                      i_clk_div,
	input  logic [7:0]                       i_cmd,
	input  logic                             i_cmd_valid,
	input  logic [2:0]                       i_sock_num,
	input  logic                             i_rw,
	input  logic [15:0]                      i_addr,
	input  logic [w5500_cmd_pkg::SIZE_W-1:0] i_byte_size,
	output logic                             o_cmd_ack,
	output logic                             o_cmd_err,
	output logic [7:0]                       o_data_out,
	output logic                             o_data_valid,
	input  logic                             i_buf_wr_en,
	input  logic [w5500_cmd_pkg::BUF_AW-1:0] i_buf_wr_addr,
	input  logic [7:0]                       i_buf_wr_data,
	output logic                             o_spi_cs,
	output logic                             o_spi_sclk,
	output logic                             o_spi_mosi,
	input  logic                             i_spi_miso
);
	import w5500_cmd_pkg::*;

	logic [BUF_AW-1:0] buf_rd_addr;
	logic [7:0]        buf_rd_data;

	spi_byte_if u_link ();

	send_buffer u_buf (
		.clk       (clk),
		.i_wr_en   (i_buf_wr_en),
		.i_wr_addr (i_buf_wr_addr),
		.i_wr_data (i_buf_wr_data),
		.i_rd_addr (buf_rd_addr),
		.o_rd_data (buf_rd_data)
	);

	spi_w5500_cmd u_cmd (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_cmd         (i_cmd),
		.i_cmd_valid   (i_cmd_valid),
		.i_sock_num    (i_sock_num),
		.i_rw          (i_rw),
		.i_addr        (i_addr),
		.i_byte_size   (i_byte_size),
		.o_cmd_ack     (o_cmd_ack),
		.o_cmd_err     (o_cmd_err),
		.o_buf_rd_addr (buf_rd_addr),
		.i_buf_rd_data (buf_rd_data),
		.o_data_out    (o_data_out),
		.o_data_valid  (o_data_valid),
		.spi           (u_link.master)
	);

	spi_master_eth u_spi (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_clk_div  (i_clk_div),
		.spi        (u_link.slave),
		.o_spi_cs   (o_spi_cs),
		.o_spi_sclk (o_spi_sclk),
		.o_spi_mosi (o_spi_mosi),
		.i_spi_miso (i_spi_miso)
	);

endmodule

/* testbench/w5500_slave_model.sv */
`timescale 1ns/1ps

module w5500_slave_model (
	input  logic i_spi_cs,
	input  logic i_spi_sclk,
	input  logic i_spi_mosi,
	output logic o_spi_miso
);

	int          nbits = 0;
	logic [15:0] frame_addr = 16'h0000;
	logic [7:0]  data_byte;
	logic        miso_q = 1'b0;

	assign o_spi_miso = miso_q;

	// low byte of the frame address plus the byte index, xored with a5.
	function automatic logic [7:0] read_pattern(input logic [15:0] addr, input int k);
		logic [15:0] a;
		a = addr + 16'(k);
		return a[7:0] ^ 8'hA5;
	endfunction

	always @(posedge i_spi_sclk or negedge i_spi_sclk or posedge i_spi_cs) begin
		if (i_spi_cs) begin
			nbits <= 0;
			miso_q <= 1'b0;
		end else if (i_spi_sclk) begin
			if (nbits < 16)
				frame_addr <= {frame_addr[14:0], i_spi_mosi}; // address phase.
			nbits <= nbits + 1;
		end else if (nbits >= 24) begin
			// next data bit goes out on the falling edge.
			data_byte = read_pattern(frame_addr, (nbits - 24) / 8) << (nbits % 8);
			miso_q <= data_byte[7];
		end
	end

endmodule

/* testbench/w5500_checker.sv */
`timescale 1ns/1ps

module w5500_checker (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        i_spi_cs,
	input  logic        i_spi_sclk,
	input  logic        i_spi_mosi,
	input  logic        i_cmd_ack,
	input  logic        i_cmd_err,
	input  logic [7:0]  i_data_out,
	input  logic        i_data_valid,
	input  int          i_test_num,
	input  logic [15:0] i_exp_addr,
	input  logic [7:0]  i_exp_ctrl,
	input  logic [15:0] i_exp_len,
	input  logic        i_exp_err,
	input  logic [7:0]  i_buf_copy [0:(1 << w5500_cmd_pkg::BUF_AW) - 1],
	output int          o_pass_cnt,
	output int          o_fail_cnt
);

	logic       sclk_q;
	logic [7:0] sh;
	int         nbits;
	int         nedges;
	int         nreads;
	int         errs;
	logic [7:0] frame [$];

	function automatic void flag_mismatch(input string msg);
		$display("ERROR @ %0t: test %0d: %s", $time, i_test_num, msg);
		errs++;
	endfunction

	function automatic void check_read_byte();
		logic [15:0] a;
		logic [7:0]  want;
		a = i_exp_addr + 16'(nreads);
		want = a[7:0] ^ 8'hA5;
		if (i_data_out !== want)
			flag_mismatch($sformatf("read byte %0d is %02h, expected %02h",
				nreads, i_data_out, want));
		nreads++;
	endfunction

	function automatic void close_test();
		int   len;
		logic wr;
		len = int'(i_exp_len);
		wr = i_exp_ctrl[2]; // rwb.
		if (i_spi_cs !== 1'b1)
			flag_mismatch("chip select still low at the end of the command");
		if (i_exp_err) begin
			if (!i_cmd_err || i_cmd_ack)
				flag_mismatch("command ended without the error strobe");
			if (frame.size() != 0 || nedges != 0)
				flag_mismatch($sformatf("%0d sclk edges on a rejected opcode", nedges));
		end else begin
			if (!i_cmd_ack || i_cmd_err)
				flag_mismatch("command ended without an acknowledge");
			if (nedges != nbits)
				flag_mismatch($sformatf("%0d sclk edges outside chip select",
					nedges - nbits));
			if (frame.size() != len + 3)
				flag_mismatch($sformatf("frame has %0d bytes, expected %0d",
					frame.size(), len + 3));
			else if ({frame[0], frame[1], frame[2]} !== {i_exp_addr, i_exp_ctrl})
				flag_mismatch($sformatf("header %02h%02h %02h, expected %04h %02h",
					frame[0], frame[1], frame[2], i_exp_addr, i_exp_ctrl));
			for (int k = 0; wr && k < len && k + 3 < frame.size(); k++)
				if (frame[k + 3] !== i_buf_copy[k])
					flag_mismatch($sformatf("data byte %0d is %02h, expected %02h",
						k, frame[k + 3], i_buf_copy[k]));
			if (nreads != (wr ? 0 : len))
				flag_mismatch($sformatf("%0d read strobes, expected %0d",
					nreads, wr ? 0 : len));
		end
		if (errs == 0) begin
			$display("test %0d passed", i_test_num);
			o_pass_cnt++;
		end else begin
			$display("test %0d failed with %0d mismatches", i_test_num, errs);
			o_fail_cnt++;
		end
		frame.delete();
		nbits = 0;
		nedges = 0;
		nreads = 0;
		errs = 0;
	endfunction

	always @(posedge clk) begin
		if (!rst_n) begin
			sclk_q = 1'b0;
			sh = 8'h00;
			nbits = 0;
			nedges = 0;
			nreads = 0;
			errs = 0;
			o_pass_cnt = 0;
			o_fail_cnt = 0;
			frame.delete();
		end else begin
			if (i_spi_sclk && !sclk_q) begin // rising sclk.
				nedges++;
				if (!i_spi_cs) begin
					sh = {sh[6:0], i_spi_mosi};
					nbits++;
					if (nbits % 8 == 0)
						frame.push_back(sh);
				end
			end
			sclk_q = i_spi_sclk;
			if (i_data_valid)
				check_read_byte();
			if (i_cmd_ack || i_cmd_err)
				close_test();
		end
	end

endmodule

/* testbench/tb_w5500_top.sv */
`timescale 1ns/1ps

module tb_w5500_top #(
	parameter int SEED = 57328
);
	import w5500_cmd_pkg::*;

	typedef struct packed {
		logic [7:0]  cmd;
		logic [2:0]  sock;
		logic        rw;
		logic [15:0] addr;
		logic [15:0] size;
		logic [15:0] div;
		logic [15:0] e_addr;
		logic [15:0] e_len;
		logic [1:0]  e_bsb;
		logic        e_rwb;
		logic        e_err;
	} row_t;

	localparam int NROWS   = 10;
	localparam int TIMEOUT = 20000; // clock cycles per command.

	logic              clk;
	logic              rst_n;
	logic [15:0]       clk_div;
	logic [7:0]        cmd;
	logic              cmd_valid;
	logic [2:0]        sock_num;
	logic              rw;
	logic [15:0]       addr;
	logic [SIZE_W-1:0] byte_size;
	logic              cmd_ack;
	logic              cmd_err;
	logic [7:0]        data_out;
	logic              data_valid;
	logic              buf_wr_en;
	logic [BUF_AW-1:0] buf_wr_addr;
	logic [7:0]        buf_wr_data;
	logic              spi_cs;
	logic              spi_sclk;
	logic              spi_mosi;
	logic              spi_miso;

	logic [15:0]       exp_addr;
	logic [7:0]        exp_ctrl;
	logic [15:0]       exp_len;
	logic              exp_err;
	int                test_num;
	int                pass_cnt;
	int                fail_cnt;
	logic              timed_out;
	row_t              tests [0:NROWS-1];
	logic [7:0]        buf_copy [0:(1 << BUF_AW) - 1];

	w5500_spi_top dut0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_clk_div     (clk_div),
		.i_cmd         (cmd),
		.i_cmd_valid   (cmd_valid),
		.i_sock_num    (sock_num),
		.i_rw          (rw),
		.i_addr        (addr),
		.i_byte_size   (byte_size),
		.o_cmd_ack     (cmd_ack),
		.o_cmd_err     (cmd_err),
		.o_data_out    (data_out),
		.o_data_valid  (data_valid),
		.i_buf_wr_en   (buf_wr_en),
		.i_buf_wr_addr (buf_wr_addr),
		.i_buf_wr_data (buf_wr_data),
		.o_spi_cs      (spi_cs),
		.o_spi_sclk    (spi_sclk),
		.o_spi_mosi    (spi_mosi),
		.i_spi_miso    (spi_miso)
	);

	w5500_slave_model slave0 (
		.i_spi_cs   (spi_cs),
		.i_spi_sclk (spi_sclk),
		.i_spi_mosi (spi_mosi),
		.o_spi_miso (spi_miso)
	);

	w5500_checker chk0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_spi_cs     (spi_cs),
		.i_spi_sclk   (spi_sclk),
		.i_spi_mosi   (spi_mosi),
		.i_cmd_ack    (cmd_ack),
		.i_cmd_err    (cmd_err),
		.i_data_out   (data_out),
		.i_data_valid (data_valid),
		.i_test_num   (test_num),
		.i_exp_addr   (exp_addr),
		.i_exp_ctrl   (exp_ctrl),
		.i_exp_len    (exp_len),
		.i_exp_err    (exp_err),
		.i_buf_copy   (buf_copy),
		.o_pass_cnt   (pass_cnt),
		.o_fail_cnt   (fail_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// common registers carry socket field zero.
	function automatic logic [7:0] ctrl_byte(input logic [2:0] s, input logic [1:0] bsb,
			input logic rwb);
		return {(bsb == 2'b00) ? 3'd0 : s, bsb, rwb, 2'b00};
	endfunction

	function automatic void set_row(input int n, input logic [7:0] c, input logic [2:0] s,
			input logic w, input logic [15:0] a, input logic [15:0] sz, input logic [15:0] d,
			input logic [15:0] ea, input logic [15:0] el, input logic [1:0] eb,
			input logic er, input logic ee);
		tests[n] = '{c, s, w, a, sz, d, ea, el, eb, er, ee};
	endfunction

	task automatic load_table();
		logic [2:0]  s;
		logic [2:0]  t;
		logic [15:0] a;
		s = 3'($urandom);
		t = 3'($urandom);
		a = 16'($urandom);
		// opcode, socket, rw, addr, size, divider, frame addr, length, block, rwb, error.
		set_row(0, SIP, s, 1'b1, 16'h0, 16'd0, 16'd1, 16'h000F, 16'd4, 2'b00, 1'b1, 1'b0);
		set_row(1, SMAC, t, 1'b1, 16'h0, 16'd0, 16'd2, 16'h0009, 16'd6, 2'b00, 1'b1, 1'b0);
		set_row(2, SOCK_STATE, s, 1'b0, 16'h0, 16'd0, 16'd1, 16'h0003, 16'd1, 2'b01, 1'b0, 1'b0);
		set_row(3, SOCK_DPORT, t, 1'b0, 16'h0, 16'd0, 16'd2, 16'h0010, 16'd2, 2'b01, 1'b0, 1'b0);
		set_row(4, SOCK_RX_SIZE, s, 1'b1, 16'h0, 16'd0, 16'd1, 16'h0026, 16'd2, 2'b01, 1'b0, 1'b0);
		set_row(5, SOCK_BUF, t, 1'b1, a, 16'd5, 16'd1, a, 16'd5, 2'b10, 1'b1, 1'b0);
		set_row(6, SOCK_BUF, t, 1'b0, a, 16'd5, 16'd2, a, 16'd5, 2'b11, 1'b0, 1'b0);
		set_row(7, 8'hEE, s, 1'b1, 16'h0, 16'd0, 16'd1, 16'h0000, 16'd0, 2'b00, 1'b1, 1'b1);
		set_row(8, GATEWAY, s, 1'b1, 16'h0, 16'd0, 16'd0, 16'h0001, 16'd4, 2'b00, 1'b1, 1'b0);
		set_row(9, GATEWAY, s, 1'b1, 16'h0, 16'd0, 16'd3, 16'h0001, 16'd4, 2'b00, 1'b1, 1'b0);
	endtask

	task automatic fill_buffer();
		logic [7:0] b;
		for (int i = 0; i < (1 << BUF_AW); i++) begin
			b = 8'($urandom);
			@(posedge clk);
			buf_wr_en <= 1'b1;
			buf_wr_addr <= BUF_AW'(i);
			buf_wr_data <= b;
			buf_copy[i] = b;
		end
		@(posedge clk);
		buf_wr_en <= 1'b0;
	endtask

	task automatic run_row(input int n, output logic hung);
		row_t r;
		int   waited;
		logic done;
		r = tests[n];
		hung = 1'b0;
		waited = 0;
		done = 1'b0;
		@(posedge clk);
		cmd <= r.cmd;
		sock_num <= r.sock;
		rw <= r.rw;
		addr <= r.addr;
		byte_size <= r.size;
		clk_div <= r.div;
		cmd_valid <= 1'b1;
		exp_addr <= r.e_addr;
		exp_ctrl <= ctrl_byte(r.sock, r.e_bsb, r.e_rwb);
		exp_len <= r.e_len;
		exp_err <= r.e_err;
		test_num <= n;
		@(posedge clk);
		cmd_valid <= 1'b0; // one sample in idle.
		while (!done && waited < TIMEOUT) begin
			@(posedge clk);
			done = cmd_ack || cmd_err;
			waited++;
		end
		if (!done) begin
			$display("command %0d timed out waiting for acknowledge", n);
			hung = 1'b1;
		end
	endtask

	initial begin
		logic hung;
		void'($urandom(SEED));
		rst_n = 1'b0;
		clk_div = 16'd0;
		cmd = 8'h00;
		cmd_valid = 1'b0;
		sock_num = 3'd0;
		rw = 1'b0;
		addr = 16'h0000;
		byte_size = '0;
		buf_wr_en = 1'b0;
		buf_wr_addr = '0;
		buf_wr_data = 8'h00;
		exp_addr = 16'h0000;
		exp_ctrl = 8'h00;
		exp_len = 16'd0;
		exp_err = 1'b0;
		test_num = 0;
		timed_out = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		fill_buffer();
		load_table();
		for (int n = 0; n < NROWS && !timed_out; n++) begin
			run_row(n, hung);
			timed_out = hung;
		end
		@(posedge clk);
		$display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
		if (!timed_out && fail_cnt == 0 && pass_cnt == NROWS)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* sources.f */
verilog/w5500_reg_pkg.sv
verilog/w5500_cmd_pkg.sv
verilog/spi_byte_if.sv
verilog/send_buffer.sv
verilog/spi_w5500_cmd.sv
verilog/spi_master_eth.sv
verilog/w5500_spi_top.sv
testbench/w5500_slave_model.sv
testbench/w5500_checker.sv
testbench/tb_w5500_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_w5500_top
SEED      ?= 57328
SIM_FLAGS ?= --assert -Wno-fatal
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "overridable: VERILATOR TOP SEED SIM_FLAGS OBJ_DIR"

test:
	$(VERILATOR) --binary --timing $(SIM_FLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(OBJ_DIR) -f sources.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)
